// File: ex_int_alu.sv
// Integer ALU with branch condition evaluation for the RV32I operations
// The result is combinational and is registered by the result select
`timescale 1ns/1ps

module ex_int_alu
    import ex_pkg::*;
(
    input  logic              issue_valid,
    input  alu_op_e           alu_op,
    input  logic [xlen-1:0]   s1,
    input  logic [xlen-1:0]   s2,
    input  logic [xlen-1:0]   pc,
    output logic [xlen-1:0]   int_result,
    output logic              int_valid,
    output logic              branch_taken
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;
    logic       cond;

    assign shamt = s2[4:0];
    assign eq    = (s1 == s2);
    assign lt_s  = ($signed(s1) < $signed(s2));
    assign lt_u  = (s1 < s2);

    always_comb begin
        int_result = '0;
        cond       = 1'b0;
        case (alu_op)
            ADD:   int_result = s1 + s2;
            SUB:   int_result = s1 - s2;
            SLL:   int_result = s1 << shamt;
            SLT:   int_result = {{(xlen-1){1'b0}}, lt_s};
            SLTU:  int_result = {{(xlen-1){1'b0}}, lt_u};
            XOR:   int_result = s1 ^ s2;
            SRL:   int_result = s1 >> shamt;
            SRA:   int_result = $signed(s1) >>> shamt;
            OR:    int_result = s1 | s2;
            AND:   int_result = s1 & s2;
            PASS2: int_result = s2; // LUI
            BEQ:   cond = eq;
            BNE:   cond = !eq;
            BLT:   cond = lt_s;
            BGE:   cond = !lt_s;
            BLTU:  cond = lt_u;
            BGEU:  cond = !lt_u;
            JAL, JALR: begin
                int_result = pc + 32'd4; // Link address
                cond       = 1'b1;
            end
            default: begin
                // Multiply and divide are handled elsewhere
                int_result = '0;
                cond       = 1'b0;
            end
        endcase
    end

    assign int_valid    = issue_valid && !is_muldiv_op(alu_op);
    assign branch_taken = issue_valid && is_branch_op(alu_op) && cond;

endmodule

// File: ex_mul_div.sv
// Single-cycle multiplier and iterative restoring divider of the M extension
// A divide holds the pipeline through stall_req until its result is ready
`timescale 1ns/1ps

module ex_mul_div
    import ex_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  alu_op_e           alu_op,
    input  logic [xlen-1:0]   s1,
    input  logic [xlen-1:0]   s2,
    output logic [xlen-1:0]   md_result,
    output logic              md_valid,
    output logic              stall_req
);

    logic signed [xlen:0]     mul_a;
    logic signed [xlen:0]     mul_b;
    logic signed [2*xlen+1:0] product;
    logic [xlen-1:0]          mul_result;
    logic                     mul_valid;

    div_state_e               state;
    logic [div_cnt_w-1:0]     count;
    logic                     div_start;
    logic                     div_signed;
    logic [xlen-1:0]          quo_q;
    logic [xlen-1:0]          rem_q;
    logic [xlen-1:0]          divisor_q;
    logic [xlen-1:0]          dividend_q;
    logic                     neg_q;
    logic                     neg_r;
    logic                     rem_sel;
    logic                     div_zero;
    logic [xlen+1:0]          step_diff;
    logic [xlen-1:0]          div_result;

    // Operands are widened by one bit so a single signed multiply covers all forms
    assign mul_a      = {(alu_op inside {MULH, MULHSU}) & s1[xlen-1], s1};
    assign mul_b      = {(alu_op == MULH) & s2[xlen-1], s2};
    assign product    = mul_a * mul_b;
    assign mul_result = (alu_op == MUL) ? product[xlen-1:0] : product[2*xlen-1:xlen];
    assign mul_valid  = issue_valid && is_muldiv_op(alu_op) && !is_div_op(alu_op);

    assign div_start  = issue_valid && is_div_op(alu_op);
    assign div_signed = alu_op inside {DIV, REM};

    // Trial subtraction of one restoring step
    assign step_diff = {1'b0, rem_q, quo_q[xlen-1]} - {2'b00, divisor_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    count <= '0;
                    if (div_start) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    count <= count + 1'b1;
                    if (count == div_cnt_w'(div_steps - 1)) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE; // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && div_start) begin
            // The divider works on magnitudes
            quo_q      <= (div_signed && s1[xlen-1]) ? -s1 : s1;
            divisor_q  <= (div_signed && s2[xlen-1]) ? -s2 : s2;
            rem_q      <= '0;
            dividend_q <= s1;
            neg_q      <= div_signed && (s1[xlen-1] ^ s2[xlen-1]);
            neg_r      <= div_signed && s1[xlen-1];
            rem_sel    <= alu_op inside {REM, REMU};
            div_zero   <= (s2 == '0);
        end else if (state == RUN) begin
            if (!step_diff[xlen+1]) begin
                rem_q <= step_diff[xlen-1:0];
                quo_q <= {quo_q[xlen-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[xlen-2:0], quo_q[xlen-1]};
                quo_q <= {quo_q[xlen-2:0], 1'b0};
            end
        end
    end

    // Signed overflow needs no special case because the sign fix already yields it
    always_comb begin
        if (div_zero) begin
            div_result = rem_sel ? dividend_q : '1;
        end else if (rem_sel) begin
            div_result = neg_r ? -rem_q : rem_q;
        end else begin
            div_result = neg_q ? -quo_q : quo_q;
        end
    end

    assign stall_req = (state == RUN) || (state == IDLE && div_start);
    assign md_valid  = (state == DONE) || mul_valid;
    assign md_result = (state == DONE) ? div_result : mul_result;

    // A stall raised in IDLE ends in DONE once the full run has passed
    a_stall_length: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE && stall_req) |-> ##(div_steps + 1) (state == DONE && !stall_req))
        else $error("Divide stall did not end in DONE after div_steps + 1 cycles");

    a_op_stable: assert property (@(posedge clk) disable iff (reset)
        (state == RUN) |-> $stable(alu_op))
        else $error("alu_op changed while the divider runs");

    a_run_bound: assert property (@(posedge clk) disable iff (reset)
        $rose(state == RUN) |-> ##[1:div_steps] (state != RUN))
        else $error("Divider stayed in RUN too long");

endmodule

// File: ex_operand_select.sv
// Operand multiplexers of the execute stage and the branch/jump target adder
// Purely combinational, fed straight from the ID/EX register
`timescale 1ns/1ps

module ex_operand_select
    import ex_pkg::*;
(
    input  src1_sel_e         src1_sel,
    input  src2_sel_e         src2_sel,
    input  alu_op_e           alu_op,
    input  logic [xlen-1:0]   rs1_data,
    input  logic [xlen-1:0]   rs2_data,
    input  logic [xlen-1:0]   pc,
    input  logic [xlen-1:0]   imm,
    output logic [xlen-1:0]   s1,
    output logic [xlen-1:0]   s2,
    output logic [xlen-1:0]   branch_target
);

    logic [xlen-1:0] jalr_sum;

    // AUIPC and JAL use the PC as first operand
    assign s1 = (src1_sel == PC) ? pc : rs1_data;

    // Immediate forms and LUI take the immediate as second operand
    assign s2 = (src2_sel == IMM) ? imm : rs2_data;

    assign jalr_sum = rs1_data + imm;

    always_comb begin
        if (alu_op == JALR) begin
            branch_target = {jalr_sum[xlen-1:1], 1'b0}; // Bit 0 is cleared for JALR
        end else begin
            branch_target = pc + imm;
        end
    end

endmodule

// File: ex_pkg.sv
// Shared types and constants of the execute stage
// Imported by every RTL module and by the testbench reference model
package ex_pkg;

    localparam int xlen      = 32;
    localparam int div_steps = 32; // One quotient bit per cycle
    localparam int div_cnt_w = $clog2(div_steps);

    typedef enum logic [4:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS2,
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
    } alu_op_e;

    typedef enum logic {
        RS1,
        PC
    } src1_sel_e;

    typedef enum logic {
        RS2,
        IMM
    } src2_sel_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_e;

    function automatic logic is_muldiv_op(alu_op_e op);
        return op inside {MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
    endfunction

    // The multi-cycle subset of the multiply/divide class
    function automatic logic is_div_op(alu_op_e op);
        return op inside {DIV, DIVU, REM, REMU};
    endfunction

    // Includes the unconditional jumps
    function automatic logic is_branch_op(alu_op_e op);
        return op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR};
    endfunction

endpackage

// File: ex_result_select.sv
// EX/MEM result register fed by the integer ALU and the multiply/divide unit
// Loads only when the pipeline is not stalled
`timescale 1ns/1ps

module ex_result_select
    import ex_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              int_valid,
    input  logic              md_valid,
    input  logic              stall_req,
    input  logic [xlen-1:0]   int_result,
    input  logic [xlen-1:0]   md_result,
    output logic [xlen-1:0]   ex_result,
    output logic              ex_valid
);

    logic load;

    assign load = !stall_req && (int_valid ^ md_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_result <= '0;
            ex_valid  <= 1'b0;
        end else begin
            ex_valid <= load;
            if (load) begin
                ex_result <= int_valid ? int_result : md_result;
            end
        end
    end

    // The two units decode disjoint opcode classes
    a_one_source: assert property (@(posedge clk) disable iff (reset)
        !(int_valid && md_valid))
        else $error("Integer and multiply/divide results valid together");

endmodule

// File: ex_stage.sv
// Execute stage of the RV32IM core, between the ID/EX register and the memory stage
// A divide raises stall_req, and upstream must then hold its outputs
`timescale 1ns/1ps

module ex_stage
    import ex_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  alu_op_e           alu_op,
    input  src1_sel_e         src1_sel,
    input  src2_sel_e         src2_sel,
    input  logic [xlen-1:0]   rs1_data,
    input  logic [xlen-1:0]   rs2_data,
    input  logic [xlen-1:0]   pc,
    input  logic [xlen-1:0]   imm,
    output logic [xlen-1:0]   ex_result,
    output logic              ex_valid,
    output logic              branch_taken,
    output logic [xlen-1:0]   branch_target,
    output logic              stall_req
);

    logic [xlen-1:0] s1;
    logic [xlen-1:0] s2;
    logic [xlen-1:0] int_result;
    logic            int_valid;
    logic [xlen-1:0] md_result;
    logic            md_valid;

    ex_operand_select u_operand_select (
        .src1_sel      (src1_sel),
        .src2_sel      (src2_sel),
        .alu_op        (alu_op),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .pc            (pc),
        .imm           (imm),
        .s1            (s1),
        .s2            (s2),
        .branch_target (branch_target)
    );

    ex_int_alu u_int_alu (
        .issue_valid  (issue_valid),
        .alu_op       (alu_op),
        .s1           (s1),
        .s2           (s2),
        .pc           (pc),
        .int_result   (int_result),
        .int_valid    (int_valid),
        .branch_taken (branch_taken)
    );

    ex_mul_div u_mul_div (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .alu_op      (alu_op),
        .s1          (s1),
        .s2          (s2),
        .md_result   (md_result),
        .md_valid    (md_valid),
        .stall_req   (stall_req)
    );

    ex_result_select u_result_select (
        .clk        (clk),
        .reset      (reset),
        .int_valid  (int_valid),
        .md_valid   (md_valid),
        .stall_req  (stall_req),
        .int_result (int_result),
        .md_result  (md_result),
        .ex_result  (ex_result),
        .ex_valid   (ex_valid)
    );

endmodule

// File: filelist.f
+incdir+.
ex_pkg.sv
ex_operand_select.sv
ex_int_alu.sv
ex_mul_div.sv
ex_result_select.sv
ex_stage.sv
tb_ex_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and look for the pass line

verilator --binary --timing --assert -f filelist.f --top-module tb_ex_stage \
    -o sim_ex_stage || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/sim_ex_stage)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1

// File: tb_ex_ref.svh
// Reference model of one execute-stage instruction for the testbench scoreboard
// Included inside the testbench module, which imports the execute package
`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

function automatic logic [xlen-1:0] select_op1(src1_sel_e sel, logic [xlen-1:0] rs1,
                                               logic [xlen-1:0] pc);
    return (sel == PC) ? pc : rs1;
endfunction

function automatic logic [xlen-1:0] select_op2(src2_sel_e sel, logic [xlen-1:0] rs2,
                                               logic [xlen-1:0] imm);
    return (sel == IMM) ? imm : rs2;
endfunction

function automatic logic [xlen-1:0] compute_result(alu_op_e op, logic [xlen-1:0] a,
                                                   logic [xlen-1:0] b, logic [xlen-1:0] pc);
    logic [2*xlen-1:0]        prod;
    logic [xlen-1:0]          min_neg;
    logic                     overflow;
    logic signed [xlen-1:0]   quo_s;
    logic signed [xlen-1:0]   rem_s;
    min_neg  = {1'b1, {(xlen-1){1'b0}}};
    overflow = (a == min_neg) && (b == '1); // Most negative divided by minus one
    case (op)
        ADD:    return a + b;
        SUB:    return a - b;
        SLL:    return a << b[4:0];
        SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        SLTU:   return (a < b) ? 32'd1 : 32'd0;
        XOR:    return a ^ b;
        SRL:    return a >> b[4:0];
        SRA:    return $signed(a) >>> b[4:0];
        OR:     return a | b;
        AND:    return a & b;
        PASS2:  return b;
        JAL, JALR: return pc + 32'd4;
        MUL, MULHU: begin
            prod = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
            return (op == MUL) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];
        end
        MULH: begin
            prod = {{xlen{a[xlen-1]}}, a} * {{xlen{b[xlen-1]}}, b};
            return prod[2*xlen-1:xlen];
        end
        MULHSU: begin
            prod = {{xlen{a[xlen-1]}}, a} * {{xlen{1'b0}}, b};
            return prod[2*xlen-1:xlen];
        end
        DIV: begin
            if (b == '0) begin
                return '1;
            end
            if (overflow) begin
                return min_neg;
            end
            quo_s = $signed(a) / $signed(b);
            return quo_s;
        end
        DIVU:   return (b == '0) ? '1 : a / b;
        REM: begin
            if (b == '0) begin
                return a;
            end
            if (overflow) begin
                return '0;
            end
            rem_s = $signed(a) % $signed(b); // Sign follows the dividend
            return rem_s;
        end
        REMU:   return (b == '0) ? a : a % b;
        default: return '0; // Conditional branches write no result
    endcase
endfunction

function automatic logic branch_resolves(alu_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    case (op)
        BEQ:       return a == b;
        BNE:       return a != b;
        BLT:       return $signed(a) < $signed(b);
        BGE:       return $signed(a) >= $signed(b);
        BLTU:      return a < b;
        BGEU:      return a >= b;
        JAL, JALR: return 1'b1;
        default:   return 1'b0;
    endcase
endfunction

function automatic logic [xlen-1:0] jump_target(alu_op_e op, logic [xlen-1:0] rs1,
                                                logic [xlen-1:0] pc, logic [xlen-1:0] imm);
    logic [xlen-1:0] t;
    t = (op == JALR) ? rs1 + imm : pc + imm;
    if (op == JALR) begin
        t[0] = 1'b0;
    end
    return t;
endfunction

function automatic logic needs_stall(alu_op_e op);
    return op inside {DIV, DIVU, REM, REMU};
endfunction

`endif

// File: tb_ex_stage.sv
// Self-checking testbench of the execute stage with a reference model and result scoreboard
// Runs integer, branch, multiply, divide and mixed instruction streams back to back
`timescale 1ns/1ps

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int n_alu          = 200;
    localparam int n_branch       = 60;
    localparam int n_mul          = 60;
    localparam int n_div          = 60;
    localparam int n_mix          = 150;
    localparam int n_total        = n_alu + n_branch + n_mul + n_div + n_mix;
    localparam int timeout_cycles = n_total * (div_steps + 3) + 100;

    localparam alu_op_e int_ops [11] = '{ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS2};
    localparam alu_op_e branch_ops [8] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR};
    localparam alu_op_e mul_ops [4] = '{MUL, MULH, MULHSU, MULHU};
    localparam alu_op_e div_ops [4] = '{DIV, DIVU, REM, REMU};

    logic            clk = 1'b0;
    logic            reset;
    logic            issue_valid;
    alu_op_e         alu_op;
    src1_sel_e       src1_sel;
    src2_sel_e       src2_sel;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] ex_result;
    logic            ex_valid;
    logic            branch_taken;
    logic [xlen-1:0] branch_target;
    logic            stall_req;

    logic [xlen-1:0] expected_q[$];
    int              errors       = 0;
    int              accepted     = 0;
    int              results_seen = 0;
    int              cycle_count  = 0;

    `include "tb_ex_ref.svh"

    ex_stage u_dut (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .alu_op        (alu_op),
        .src1_sel      (src1_sel),
        .src2_sel      (src2_sel),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .pc            (pc),
        .imm           (imm),
        .ex_result     (ex_result),
        .ex_valid      (ex_valid),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .stall_req     (stall_req)
    );

    always #10 clk = ~clk;

    task automatic check_result(input string what, input logic [xlen-1:0] got,
                                input logic [xlen-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_target(input string what, input logic [xlen-1:0] got,
                                input logic [xlen-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Biased towards the usual corner values of the M extension
    function automatic logic [xlen-1:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return 32'd1;
            2:       return '1;
            3:       return 32'h8000_0000;
            4:       return 32'h7fff_ffff;
            default: return $urandom();
        endcase
    endfunction

    // Called at 1 ns after a rising edge, returns at the same point after acceptance
    task automatic issue_instr(input alu_op_e op, input src1_sel_e sel1, input src2_sel_e sel2,
                               input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        logic [xlen-1:0] p;
        logic [xlen-1:0] i;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
        int              stall_cycles;
        p            = $urandom() & 32'hffff_fffc;
        i            = $urandom();
        op1          = select_op1(sel1, a, p);
        op2          = select_op2(sel2, b, i);
        stall_cycles = 0;
        issue_valid  = 1'b1;
        alu_op       = op;
        src1_sel     = sel1;
        src2_sel     = sel2;
        rs1_data     = a;
        rs2_data     = b;
        pc           = p;
        imm          = i;
        @(negedge clk);
        check_flag($sformatf("branch_taken of %s", op.name()), branch_taken,
                   branch_resolves(op, op1, op2));
        check_target($sformatf("branch_target of %s", op.name()), branch_target,
                     jump_target(op, a, p, i));
        check_flag($sformatf("stall_req on issue of %s", op.name()), stall_req, needs_stall(op));
        while (stall_req) begin
            stall_cycles++;
            if (stall_cycles > 1) begin
                check_flag("ex_valid during a divide stall", ex_valid, 1'b0);
            end
            @(negedge clk);
        end
        if (needs_stall(op)) begin
            check_flag("divide stall length", stall_cycles == div_steps + 1, 1'b1);
        end
        @(posedge clk);
        #1;
        expected_q.push_back(compute_result(op, op1, op2, p));
        accepted++;
    endtask

    task automatic run_int_op();
        alu_op_e   op;
        src1_sel_e sel1;
        src2_sel_e sel2;
        op   = int_ops[$urandom_range(0, 10)];
        sel1 = ($urandom_range(0, 1) == 0) ? RS1 : PC;
        sel2 = ($urandom_range(0, 1) == 0) ? RS2 : IMM;
        issue_instr(op, sel1, sel2, pick_operand(), pick_operand());
    endtask

    task automatic run_branch_op();
        alu_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        int              kind;
        op   = branch_ops[$urandom_range(0, 7)];
        a    = pick_operand();
        kind = $urandom_range(0, 2);
        if (kind == 0) begin
            b = a;
        end else if (kind == 1) begin
            b = a + 32'd1 + ($urandom() & 32'hff);
        end else begin
            b = a - 32'd1 - ($urandom() & 32'hff);
        end
        if (op == JAL) begin
            issue_instr(op, PC, IMM, a, b);
        end else if (op == JALR) begin
            issue_instr(op, RS1, IMM, a, b);
        end else begin
            issue_instr(op, RS1, RS2, a, b);
        end
    endtask

    task automatic run_div_op(input alu_op_e op, input int kind);
        if (kind == 0) begin
            issue_instr(op, RS1, RS2, pick_operand(), '0);
        end else if (kind == 1) begin
            issue_instr(op, RS1, RS2, 32'h8000_0000, '1);
        end else begin
            issue_instr(op, RS1, RS2, pick_operand(), pick_operand());
        end
    endtask

    // Results must come back in issue order
    always @(negedge clk) begin
        if (!reset && ex_valid) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("Error at %0t: ex_valid is high but no instruction is pending", $time);
            end else begin
                check_result("ex_result", ex_result, expected_q.pop_front());
                results_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Run stopped after %0d cycles, the streams did not finish", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32));
        reset       = 1'b1;
        issue_valid = 1'b0;
        alu_op      = ADD;
        src1_sel    = RS1;
        src2_sel    = RS2;
        rs1_data    = '0;
        rs2_data    = '0;
        pc          = '0;
        imm         = '0;
        repeat (8) begin
            @(posedge clk);
            #1;
            check_flag("ex_valid in reset", ex_valid, 1'b0);
            check_flag("stall_req in reset", stall_req, 1'b0);
            check_flag("branch_taken in reset", branch_taken, 1'b0);
        end
        reset = 1'b0;
        @(negedge clk);
        check_flag("ex_valid after reset", ex_valid, 1'b0);
        check_flag("stall_req after reset", stall_req, 1'b0);
        check_flag("branch_taken after reset", branch_taken, 1'b0);
        @(posedge clk);
        #1;
        repeat (n_alu) run_int_op();
        repeat (n_branch) run_branch_op();
        for (int n = 0; n < n_mul; n++) begin
            issue_instr(mul_ops[n % 4], RS1, RS2, pick_operand(), pick_operand());
        end
        for (int n = 0; n < n_div; n++) begin
            run_div_op(div_ops[n % 4], n / 4); // First rounds hit the RISC-V corner cases
        end
        repeat (n_mix) begin
            case ($urandom_range(0, 3))
                0:       run_int_op();
                1:       run_branch_op();
                2:       issue_instr(mul_ops[$urandom_range(0, 3)], RS1, RS2,
                                     pick_operand(), pick_operand());
                default: run_div_op(div_ops[$urandom_range(0, 3)], $urandom_range(0, 5));
            endcase
        end
        issue_valid = 1'b0;
        repeat (4) @(negedge clk);
        if (results_seen != accepted || expected_q.size() != 0) begin
            errors++;
            $display("Error: %0d instructions accepted but %0d results seen", accepted,
                     results_seen);
        end
        $display("Errors: %0d, accepted: %0d, results checked: %0d", errors, accepted,
                 results_seen);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
